// ==== design/io_map_pkg.sv ====
`default_nettype none

package io_map_pkg;

  typedef logic [3:0] nibble_t;
  typedef logic [7:0] io_offset_t;

  // Interrupt factors, read to clear
  localparam io_offset_t OFS_CLK_FACTOR   = 8'h00;
  localparam io_offset_t OFS_PT_FACTOR    = 8'h02;
  localparam io_offset_t OFS_K0_FACTOR    = 8'h04;
  localparam io_offset_t OFS_K1_FACTOR    = 8'h05;

  // Interrupt masks
  localparam io_offset_t OFS_CLK_MASK     = 8'h10;
  localparam io_offset_t OFS_PT_MASK      = 8'h12;
  localparam io_offset_t OFS_K0_MASK      = 8'h14;
  localparam io_offset_t OFS_K1_MASK      = 8'h15;

  localparam io_offset_t OFS_TIMER_LO     = 8'h20;
  localparam io_offset_t OFS_TIMER_HI     = 8'h21;
  localparam io_offset_t OFS_PT_VALUE_LO  = 8'h24;
  localparam io_offset_t OFS_PT_VALUE_HI  = 8'h25;
  localparam io_offset_t OFS_PT_RELOAD_LO = 8'h26;
  localparam io_offset_t OFS_PT_RELOAD_HI = 8'h27;

  localparam io_offset_t OFS_K0_VALUE     = 8'h40;
  localparam io_offset_t OFS_K0_RELATION  = 8'h41;
  localparam io_offset_t OFS_K1_VALUE     = 8'h42;

  localparam io_offset_t OFS_TIMER_RESET  = 8'h76;
  localparam io_offset_t OFS_PT_CONTROL   = 8'h78;
  localparam io_offset_t OFS_PT_SOURCE    = 8'h79;

  // Manager side of the AXI4-Lite port
  typedef struct packed {
    logic        awvalid;
    logic [9:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [9:0]  araddr;
    logic        rready;
  } axi_req_t;

  // Subordinate side
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axi_rsp_t;

endpackage

`default_nettype wire

// ==== design/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

  // Latched interrupt factors
  typedef struct packed {
    logic [3:0] clock;
    logic       prog_timer;
    logic       input_k0;
    logic       input_k1;
  } factor_t;

  typedef struct packed {
    logic [3:0] clock;
    logic       prog_timer;
    logic [3:0] input_k0;
    logic [3:0] input_k1;
  } mask_t;

  // One-cycle events from the timers and the key port
  typedef struct packed {
    logic [3:0] clock;
    logic       prog_timer;
    logic [3:0] edge_k0;
    logic [3:0] edge_k1;
  } factor_set_t;

  // Read-to-clear pulses, one K0/K1 read clears both input factors
  typedef struct packed {
    logic clock;
    logic prog_timer;
    logic inputs;
  } factor_clear_t;

  typedef struct packed {
    logic clock;
    logic prog_timer;
    logic input_k0;
    logic input_k1;
  } irq_t;

endpackage

`default_nettype wire

// ==== design/clock_timer.sv ====
`default_nettype none

module clock_timer #(
  parameter int TICK_DIV = 128
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       tick,
  input  logic       timer_reset,
  output logic [7:0] timer_value,
  output logic       step,
  output logic [3:0] clock_set
);

  localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICK_DIV - 1);

  logic [DIV_W-1:0] div_count;
  logic [7:0]       next_value;
  logic [7:0]       fall;

  // One advance per TICK_DIV ticks
  assign step = tick && (div_count == DIV_LAST) && !timer_reset;
  assign next_value = timer_value + 8'd1;

  always_ff @(posedge clk) begin
    if (!reset_n || timer_reset) begin
      div_count <= '0;
      timer_value <= '0;
    end else if (tick) begin
      if (div_count == DIV_LAST) begin
        div_count <= '0;
        timer_value <= next_value;
      end else begin
        div_count <= div_count + 1'b1;
      end
    end
  end

  // 32, 8, 2 and 1 Hz factors on the falling edge of their bits
  assign fall = timer_value & ~next_value;
  assign clock_set = step ? {fall[7], fall[6], fall[4], fall[2]} : 4'b0000;

endmodule

`default_nettype wire

// ==== design/prog_timer.sv ====
`default_nettype none

module prog_timer (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       step,
  input  logic       k03_rise,
  input  logic       pt_source,
  input  logic       pt_enable,
  input  logic       pt_load,
  input  logic [7:0] pt_reload,
  output logic [7:0] pt_value,
  output logic       underflow
);

  logic src_pulse;
  logic reload_now;
  logic dec_now;

  // Source 0 selects the clock timer step and 1 the K03 rising edge
  assign src_pulse = pt_source ? k03_rise : step;

  // A counter sitting at zero reloads on the next pulse
  assign reload_now = pt_load || (src_pulse && pt_enable && (pt_value == 8'd0));
  assign dec_now = src_pulse && pt_enable && !pt_load && (pt_value != 8'd0);

  assign underflow = dec_now && (pt_value == 8'd1);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pt_value <= '0;
    end else if (reload_now) begin
      pt_value <= pt_reload;
    end else if (dec_now) begin
      pt_value <= pt_value - 8'd1;
    end
  end

  // Software load arrives as a single-cycle strobe
  a_load_pulse: assert property (
    @(posedge clk) disable iff (!reset_n)
    pt_load |=> !pt_load
  );

endmodule

`default_nettype wire

// ==== design/input_port.sv ====
`default_nettype none

module input_port
  import io_map_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,
  input  nibble_t input_k0,
  input  nibble_t input_k1,
  input  nibble_t relation_k0,
  output nibble_t key_k0,
  output nibble_t key_k1,
  output nibble_t edge_k0,
  output nibble_t edge_k1,
  output logic    k03_rise
);

  nibble_t k0_meta;
  nibble_t k1_meta;
  nibble_t k0_prev;
  nibble_t k1_prev;

  // Two-flop synchronizer, then one more stage for edge detection
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      k0_meta <= '0;
      k1_meta <= '0;
      key_k0 <= '0;
      key_k1 <= '0;
      k0_prev <= '0;
      k1_prev <= '0;
    end else begin
      k0_meta <= input_k0;
      k1_meta <= input_k1;
      key_k0 <= k0_meta;
      key_k1 <= k1_meta;
      k0_prev <= key_k0;
      k1_prev <= key_k1;
    end
  end

  // Relation 1 picks falling edges, 0 picks rising
  assign edge_k0 = (relation_k0 & k0_prev & ~key_k0) | (~relation_k0 & ~k0_prev & key_k0);
  assign edge_k1 = k1_prev & ~key_k1;

  assign k03_rise = !k0_prev[3] && key_k0[3];

endmodule

`default_nettype wire

// ==== design/interrupt_ctrl.sv ====
`default_nettype none

module interrupt_ctrl
  import periph_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  factor_set_t   factor_set,
  input  factor_clear_t factor_clear,
  input  mask_t         masks,
  output factor_t       factors,
  output irq_t          irq
);

  logic set_k0;
  logic set_k1;

  // Key edges only count where the mask allows them
  assign set_k0 = |(factor_set.edge_k0 & masks.input_k0);
  assign set_k1 = |(factor_set.edge_k1 & masks.input_k1);

  // Set wins over a clear in the same cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      factors <= '0;
    end else begin
      factors.clock <= factor_set.clock | (factors.clock & {4{!factor_clear.clock}});
      factors.prog_timer <= factor_set.prog_timer |
                            (factors.prog_timer && !factor_clear.prog_timer);
      factors.input_k0 <= set_k0 | (factors.input_k0 && !factor_clear.inputs);
      factors.input_k1 <= set_k1 | (factors.input_k1 && !factor_clear.inputs);
    end
  end

  assign irq.clock = |(factors.clock & masks.clock);
  assign irq.prog_timer = factors.prog_timer && masks.prog_timer;
  assign irq.input_k0 = factors.input_k0 && (|masks.input_k0);
  assign irq.input_k1 = factors.input_k1 && (|masks.input_k1);

  // Read-to-clear pulses last one cycle
  a_clear_pulse: assert property (
    @(posedge clk) disable iff (!reset_n)
    (factor_clear != '0) |=> (factor_clear == '0)
  );

endmodule

`default_nettype wire

// ==== design/io_register_file.sv ====
`default_nettype none

module io_register_file
  import io_map_pkg::*, periph_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  axi_req_t      axi_req,
  output axi_rsp_t      axi_rsp,
  input  nibble_t       key_k0,
  input  nibble_t       key_k1,
  input  logic [7:0]    timer_value,
  input  logic [7:0]    pt_value,
  input  factor_t       factors,
  output mask_t         masks,
  output factor_clear_t factor_clear,
  output logic          timer_reset,
  output logic [7:0]    pt_reload,
  output logic          pt_enable,
  output logic          pt_load,
  output logic          pt_source,
  output nibble_t       relation_k0
);

  logic       wr_accept;
  logic       rd_accept;
  io_offset_t wr_ofs;
  io_offset_t rd_ofs;
  nibble_t    wr_nib;
  nibble_t    rd_nib;
  logic       bvalid;
  logic       rvalid;
  logic [31:0] rdata;

  // No new request while the previous response is still pending
  assign wr_accept = axi_req.awvalid && axi_req.wvalid && !bvalid;
  assign rd_accept = axi_req.arvalid && !rvalid;

  assign wr_ofs = axi_req.awaddr[9:2];
  assign rd_ofs = axi_req.araddr[9:2];
  assign wr_nib = axi_req.wdata[3:0];

  always_comb begin
    axi_rsp = '0;
    axi_rsp.awready = wr_accept;
    axi_rsp.wready = wr_accept;
    axi_rsp.bvalid = bvalid;
    axi_rsp.arready = rd_accept;
    axi_rsp.rvalid = rvalid;
    axi_rsp.rdata = rdata;
  end

  // Clears go out in the accept cycle, rdata still holds the old flags
  assign factor_clear.clock = rd_accept && (rd_ofs == OFS_CLK_FACTOR);
  assign factor_clear.prog_timer = rd_accept && (rd_ofs == OFS_PT_FACTOR);
  assign factor_clear.inputs = rd_accept &&
                               ((rd_ofs == OFS_K0_FACTOR) || (rd_ofs == OFS_K1_FACTOR));

  always_comb begin
    case (rd_ofs)
      OFS_CLK_FACTOR:   rd_nib = factors.clock;
      OFS_PT_FACTOR:    rd_nib = {3'b000, factors.prog_timer};
      OFS_K0_FACTOR:    rd_nib = {3'b000, factors.input_k0};
      OFS_K1_FACTOR:    rd_nib = {3'b000, factors.input_k1};
      OFS_CLK_MASK:     rd_nib = masks.clock;
      OFS_PT_MASK:      rd_nib = {3'b000, masks.prog_timer};
      OFS_K0_MASK:      rd_nib = masks.input_k0;
      OFS_K1_MASK:      rd_nib = masks.input_k1;
      OFS_TIMER_LO:     rd_nib = timer_value[3:0];
      OFS_TIMER_HI:     rd_nib = timer_value[7:4];
      OFS_PT_VALUE_LO:  rd_nib = pt_value[3:0];
      OFS_PT_VALUE_HI:  rd_nib = pt_value[7:4];
      OFS_PT_RELOAD_LO: rd_nib = pt_reload[3:0];
      OFS_PT_RELOAD_HI: rd_nib = pt_reload[7:4];
      OFS_K0_VALUE:     rd_nib = key_k0;
      OFS_K0_RELATION:  rd_nib = relation_k0;
      OFS_K1_VALUE:     rd_nib = key_k1;
      OFS_PT_CONTROL:   rd_nib = {3'b000, pt_enable};
      OFS_PT_SOURCE:    rd_nib = {3'b000, pt_source};
      // Unmapped and write-only offsets
      default:          rd_nib = 4'h0;
    endcase
  end

  // Response channels
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (axi_req.bready) begin
        bvalid <= 1'b0;
      end
      if (rd_accept) begin
        rvalid <= 1'b1;
      end else if (axi_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata <= {28'h0000000, rd_nib};
    end
  end

  // Control registers and one-cycle strobes
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      masks <= '0;
      pt_reload <= '0;
      pt_enable <= 1'b0;
      pt_source <= 1'b0;
      relation_k0 <= 4'hF;
      timer_reset <= 1'b0;
      pt_load <= 1'b0;
    end else begin
      timer_reset <= 1'b0;
      pt_load <= 1'b0;
      if (wr_accept && axi_req.wstrb[0]) begin
        case (wr_ofs)
          OFS_CLK_MASK:     masks.clock <= wr_nib;
          OFS_PT_MASK:      masks.prog_timer <= wr_nib[0];
          OFS_K0_MASK:      masks.input_k0 <= wr_nib;
          OFS_K1_MASK:      masks.input_k1 <= wr_nib;
          OFS_PT_RELOAD_LO: pt_reload[3:0] <= wr_nib;
          OFS_PT_RELOAD_HI: pt_reload[7:4] <= wr_nib;
          OFS_K0_RELATION:  relation_k0 <= wr_nib;
          OFS_TIMER_RESET:  timer_reset <= wr_nib[1];
          OFS_PT_CONTROL: begin
            pt_enable <= wr_nib[0];
            pt_load <= wr_nib[1];
          end
          OFS_PT_SOURCE:    pt_source <= wr_nib[0];
          default: ;
        endcase
      end
    end
  end

  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (!reset_n)
    bvalid && !axi_req.bready |=> bvalid
  );

  a_rdata_hold: assert property (
    @(posedge clk) disable iff (!reset_n)
    rvalid && !axi_req.rready |=> rvalid && $stable(rdata)
  );

endmodule

`default_nettype wire

// ==== design/mcu_io_top.sv ====
`default_nettype none

module mcu_io_top
  import io_map_pkg::*, periph_pkg::*;
#(
  parameter int TICK_DIV = 128
) (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     tick,
  input  nibble_t  input_k0,
  input  nibble_t  input_k1,
  input  axi_req_t axi_req,
  output axi_rsp_t axi_rsp,
  output irq_t     irq
);

  mask_t         masks;
  factor_t       factors;
  factor_set_t   factor_set;
  factor_clear_t factor_clear;

  nibble_t    key_k0;
  nibble_t    key_k1;
  nibble_t    relation_k0;
  nibble_t    edge_k0;
  nibble_t    edge_k1;
  logic       k03_rise;
  logic       timer_reset;
  logic [7:0] timer_value;
  logic       step;
  logic [3:0] clock_set;
  logic [7:0] pt_reload;
  logic [7:0] pt_value;
  logic       pt_enable;
  logic       pt_load;
  logic       pt_source;
  logic       underflow;

  io_register_file regs_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .axi_req      (axi_req),
    .axi_rsp      (axi_rsp),
    .key_k0       (key_k0),
    .key_k1       (key_k1),
    .timer_value  (timer_value),
    .pt_value     (pt_value),
    .factors      (factors),
    .masks        (masks),
    .factor_clear (factor_clear),
    .timer_reset  (timer_reset),
    .pt_reload    (pt_reload),
    .pt_enable    (pt_enable),
    .pt_load      (pt_load),
    .pt_source    (pt_source),
    .relation_k0  (relation_k0)
  );

  clock_timer #(
    .TICK_DIV (TICK_DIV)
  ) clock_timer_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .tick        (tick),
    .timer_reset (timer_reset),
    .timer_value (timer_value),
    .step        (step),
    .clock_set   (clock_set)
  );

  prog_timer prog_timer_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .step      (step),
    .k03_rise  (k03_rise),
    .pt_source (pt_source),
    .pt_enable (pt_enable),
    .pt_load   (pt_load),
    .pt_reload (pt_reload),
    .pt_value  (pt_value),
    .underflow (underflow)
  );

  input_port input_port_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .input_k0    (input_k0),
    .input_k1    (input_k1),
    .relation_k0 (relation_k0),
    .key_k0      (key_k0),
    .key_k1      (key_k1),
    .edge_k0     (edge_k0),
    .edge_k1     (edge_k1),
    .k03_rise    (k03_rise)
  );

  // Gather the set events for the factor flags
  assign factor_set.clock = clock_set;
  assign factor_set.prog_timer = underflow;
  assign factor_set.edge_k0 = edge_k0;
  assign factor_set.edge_k1 = edge_k1;

  interrupt_ctrl interrupt_ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .factor_set   (factor_set),
    .factor_clear (factor_clear),
    .masks        (masks),
    .factors      (factors),
    .irq          (irq)
  );

endmodule

`default_nettype wire

// ==== testbench/io_checker.sv ====
`default_nettype none

module io_checker
  import io_map_pkg::*, periph_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  axi_req_t   axi_req,
  input  axi_rsp_t   axi_rsp,
  input  irq_t       irq,
  input  logic       exp_push,
  input  logic       exp_irq,
  input  io_offset_t exp_offset,
  input  logic [7:0] exp_value,
  output int         check_count,
  output int         error_count
);

  // Outstanding reads as {offset, expected nibble}
  logic [15:0] exp_q[$];
  logic        r_wait;
  logic        b_wait;
  logic [31:0] r_last;

  task automatic log_failure(input string line);
    error_count++;
    $display("%s", line);
  endtask

  initial begin
    check_count = 0;
    error_count = 0;
    r_wait = 1'b0;
    b_wait = 1'b0;
    r_last = '0;
  end

  // Sample at the falling edge, where everything driven at the rising edge has settled
  always @(negedge clk) begin : watch
    logic [15:0] entry;
    if (reset_n) begin
      if (exp_push && exp_irq) begin
        check_count++;
        if (irq !== exp_value[3:0]) begin
          log_failure($sformatf("FAILED irq: got 0x%h, expected 0x%h", irq, exp_value[3:0]));
        end else begin
          $display("ok irq = 0x%h", irq);
        end
      end else if (exp_push) begin
        exp_q.push_back({exp_offset, exp_value});
      end

      // A waiting response must hold until it is taken
      if (r_wait && !axi_rsp.rvalid) begin
        log_failure("rvalid dropped while rready was low");
      end else if (r_wait && (axi_rsp.rdata !== r_last)) begin
        log_failure($sformatf("FAILED rdata held: got 0x%h, expected 0x%h",
                              axi_rsp.rdata, r_last));
      end
      if (b_wait && !axi_rsp.bvalid) begin
        log_failure("bvalid dropped while bready was low");
      end

      if (axi_rsp.rvalid && axi_req.rready) begin
        check_count++;
        if (exp_q.size() == 0) begin
          log_failure("read response arrived with no read outstanding");
        end else begin
          entry = exp_q.pop_front();
          if (axi_rsp.rdata !== {24'h000000, entry[7:0]}) begin
            log_failure($sformatf("FAILED rdata at 0x%h: got 0x%h, expected 0x%h",
                                  entry[15:8], axi_rsp.rdata, {24'h000000, entry[7:0]}));
          end else if (axi_rsp.rresp !== 2'b00) begin
            log_failure($sformatf("FAILED rresp at 0x%h: got 0x%h, expected 0x0",
                                  entry[15:8], axi_rsp.rresp));
          end else begin
            $display("ok read 0x%h = 0x%h", entry[15:8], axi_rsp.rdata[3:0]);
          end
        end
      end
      if (axi_rsp.bvalid && axi_req.bready && (axi_rsp.bresp !== 2'b00)) begin
        log_failure($sformatf("FAILED bresp: got 0x%h, expected 0x0", axi_rsp.bresp));
      end

      r_wait = axi_rsp.rvalid && !axi_req.rready;
      r_last = axi_rsp.rdata;
      b_wait = axi_rsp.bvalid && !axi_req.bready;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
`default_nettype none

module tb_top
  import io_map_pkg::*, periph_pkg::*;
();

  localparam int MAX_OPS = 256;
  localparam int OP_MARGIN = 40;

  logic       clk;
  logic       reset_n;
  logic       tick;
  nibble_t    input_k0;
  nibble_t    input_k1;
  axi_req_t   axi_req;
  axi_rsp_t   axi_rsp;
  irq_t       irq;
  logic       exp_push;
  logic       exp_irq;
  io_offset_t exp_offset;
  logic [7:0] exp_value;
  int         check_count;
  int         error_count;
  int         local_errors;
  int         op_count;
  int         watchdog_limit;
  logic       watchdog_armed;
  logic [31:0] lcg_state;
  logic [15:0] stim [0:4*MAX_OPS-1];

  mcu_io_top #(
    .TICK_DIV (4)
  ) dut_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .tick     (tick),
    .input_k0 (input_k0),
    .input_k1 (input_k1),
    .axi_req  (axi_req),
    .axi_rsp  (axi_rsp),
    .irq      (irq)
  );

  io_checker checker_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .axi_req     (axi_req),
    .axi_rsp     (axi_rsp),
    .irq         (irq),
    .exp_push    (exp_push),
    .exp_irq     (exp_irq),
    .exp_offset  (exp_offset),
    .exp_value   (exp_value),
    .check_count (check_count),
    .error_count (error_count)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic pick_delay(input int min_d, input int span, output int d);
    lcg_state = lcg_next(lcg_state);
    d = min_d + (int'({27'd0, lcg_state[20:16]}) % span);
  endtask

  task automatic axi_write(input io_offset_t ofs, input nibble_t data);
    int d;
    @(posedge clk);
    axi_req.awvalid <= 1'b1;
    axi_req.awaddr <= {ofs, 2'b00};
    axi_req.wvalid <= 1'b1;
    axi_req.wdata <= {28'h0000000, data};
    axi_req.wstrb <= 4'hF;
    @(negedge clk);
    while (!(axi_rsp.awready && axi_rsp.wready)) @(negedge clk);
    @(posedge clk);
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid <= 1'b0;
    pick_delay(0, 3, d);
    repeat (d) @(posedge clk);
    axi_req.bready <= 1'b1;
    @(negedge clk);
    while (!axi_rsp.bvalid) @(negedge clk);
    @(posedge clk);
    axi_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input io_offset_t ofs, input logic [7:0] value,
                          input int min_d, input int span);
    int d;
    // Hand the expected value to the checker one cycle ahead of the request
    @(posedge clk);
    exp_push <= 1'b1;
    exp_irq <= 1'b0;
    exp_offset <= ofs;
    exp_value <= value;
    @(posedge clk);
    exp_push <= 1'b0;
    axi_req.arvalid <= 1'b1;
    axi_req.araddr <= {ofs, 2'b00};
    @(negedge clk);
    while (!axi_rsp.arready) @(negedge clk);
    @(posedge clk);
    axi_req.arvalid <= 1'b0;
    pick_delay(min_d, span, d);
    repeat (d) @(posedge clk);
    axi_req.rready <= 1'b1;
    @(negedge clk);
    while (!axi_rsp.rvalid) @(negedge clk);
    @(posedge clk);
    axi_req.rready <= 1'b0;
  endtask

  task automatic irq_expect(input logic [7:0] value);
    @(posedge clk);
    exp_push <= 1'b1;
    exp_irq <= 1'b1;
    exp_value <= value;
    @(posedge clk);
    exp_push <= 1'b0;
    exp_irq <= 1'b0;
  endtask

  initial begin
    int base;
    clk = 1'b0;
    reset_n = 1'b0;
    tick = 1'b0;
    input_k0 = '0;
    input_k1 = '0;
    axi_req = '0;
    exp_push = 1'b0;
    exp_irq = 1'b0;
    exp_offset = '0;
    exp_value = '0;
    local_errors = 0;
    lcg_state = 32'h8677;
    watchdog_armed = 1'b0;
    for (int i = 0; i < 4 * MAX_OPS; i++) begin
      stim[i] = '0;
    end
    $readmemh("testbench/io_stimulus.hex", stim);

    // Run length is the tick and idle cycles plus a margin per operation
    op_count = 0;
    watchdog_limit = 20;
    while ((op_count < MAX_OPS) && (stim[4 * op_count] != 16'h0000)) begin
      base = 4 * op_count;
      watchdog_limit += OP_MARGIN;
      if ((stim[base] == 16'h0004) || (stim[base] == 16'h0007)) begin
        watchdog_limit += int'(stim[base + 2]);
      end
      op_count++;
    end
    watchdog_armed = 1'b1;

    repeat (5) @(posedge clk);
    reset_n <= 1'b1;

    for (int i = 0; i < op_count; i++) begin
      base = 4 * i;
      case (stim[base])
        16'h0001: axi_write(stim[base + 1][7:0], stim[base + 2][3:0]);
        16'h0002: axi_read(stim[base + 1][7:0], stim[base + 3][7:0], 0, 3);
        16'h0003: begin
          @(posedge clk);
          input_k0 <= stim[base + 2][3:0];
          input_k1 <= stim[base + 2][7:4];
        end
        16'h0004: begin
          @(posedge clk);
          tick <= 1'b1;
          repeat (int'(stim[base + 2])) @(posedge clk);
          tick <= 1'b0;
        end
        // Read with rready held back for several cycles
        16'h0005: axi_read(stim[base + 1][7:0], stim[base + 3][7:0], 4, 8);
        16'h0006: irq_expect(stim[base + 3][7:0]);
        16'h0007: repeat (int'(stim[base + 2])) @(posedge clk);
        default: begin
          local_errors++;
          $display("unknown operation code 0x%h in stimulus entry %0d", stim[base], i);
        end
      endcase
    end

    repeat (5) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count + local_errors);
    if ((error_count + local_errors == 0) && (op_count > 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (watchdog_armed);
    repeat (watchdog_limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/io_stimulus.hex ====
// Columns: op, offset, data, expected
// Ops 1 write, 2 read, 3 keys {k1,k0}, 4 tick cycles, 5 stalled read, 6 irq, 7 idle, 0 end
1 10 00A 00
2 10 000 0A
1 12 001 00
2 12 000 01
1 14 005 00
2 14 000 05
1 15 00C 00
2 15 000 0C
1 26 003 00
2 26 000 03
2 27 000 00
1 41 006 00
2 41 000 06
1 79 001 00
2 79 000 01
1 79 000 00
1 33 00F 00
2 33 000 00
2 76 000 00
// Clock timer, 20 steps then 12 more
1 76 002 00
4 00 050 00
2 20 000 04
2 21 000 01
6 00 000 00
2 00 000 01
2 00 000 00
1 10 001 00
4 00 030 00
6 00 000 08
2 20 000 00
2 21 000 02
2 00 000 03
6 00 000 00
// Programmable timer, reload 3 on the step source
1 78 003 00
4 00 00C 00
2 24 000 00
6 00 000 04
1 12 000 00
6 00 000 00
1 12 001 00
6 00 000 04
2 02 000 01
2 02 000 00
6 00 000 00
1 78 000 00
// Key edges, relation 6 then 9
3 00 002 00
7 00 006 00
6 00 000 00
2 40 000 02
3 00 003 00
7 00 006 00
6 00 000 02
2 04 000 01
6 00 000 00
3 00 007 00
7 00 006 00
6 00 000 00
3 00 003 00
7 00 006 00
6 00 000 02
2 04 000 01
3 00 00B 00
7 00 006 00
2 04 000 00
3 00 0FB 00
7 00 006 00
6 00 000 00
3 00 03B 00
7 00 006 00
6 00 000 01
2 42 000 03
2 05 000 01
6 00 000 00
1 41 009 00
3 00 03A 00
7 00 006 00
6 00 000 02
2 04 000 01
// Stalled reads
5 41 000 09
5 14 000 05
5 20 000 03
5 21 000 02
5 26 000 03
5 24 000 00
0 00 000 00

// ==== project.f ====
design/io_map_pkg.sv
design/periph_pkg.sv
design/clock_timer.sv
design/prog_timer.sv
design/input_port.sv
design/interrupt_ctrl.sv
design/io_register_file.sv
design/mcu_io_top.sv
testbench/io_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       := tb_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "sim failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
